// File: src/decode_pkg.sv
// RV32I decode package
// Fixed widths of the decode stage and the enums shared by the decoder,
// the dispatch registers and the top level

package decode_pkg;

    localparam int DATA_WIDTH    = 32;
    localparam int ADDR_WIDTH    = 32;
    localparam int REG_IDX_WIDTH = 5;
    localparam int ROB_TAG_WIDTH = 5;
    localparam int NUM_SRC       = 2;

    // Major opcodes of the RV32I base set handled by the decoder
    typedef enum logic [6:0] {
        RV_OPCODE_OPIMM  = 7'b0010011,
        RV_OPCODE_LUI    = 7'b0110111,
        RV_OPCODE_AUIPC  = 7'b0010111,
        RV_OPCODE_OP     = 7'b0110011,
        RV_OPCODE_JAL    = 7'b1101111,
        RV_OPCODE_JALR   = 7'b1100111,
        RV_OPCODE_BRANCH = 7'b1100011,
        RV_OPCODE_LOAD   = 7'b0000011,
        RV_OPCODE_STORE  = 7'b0100011
    } rv_opcode_t;

    // Internal operations executed by the functional units
    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_LT, OP_LTU, OP_AND,
        OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA,
        OP_EQ, OP_NE, OP_GE, OP_GEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_UNDEFINED
    } op_t;

    // Operation class, which steers the ROB and the RS towards the
    // right execution path
    typedef enum logic [2:0] {
        OP_IS_OP,
        OP_IS_LD,
        OP_IS_ST,
        OP_IS_BR,
        OP_IS_JL
    } op_is_t;

endpackage

// File: src/decoded_insn_if.sv
// Decoded instruction bundle
// Carries the decoder results to the operand selector and the dispatch registers

interface decoded_insn_if import decode_pkg::*; ();

    op_t                      op;
    op_is_t                   op_is;
    logic [ADDR_WIDTH-1:0]    pc;
    logic [DATA_WIDTH-1:0]    imm;
    logic [REG_IDX_WIDTH-1:0] rdst;
    // Link value written by JAL and JALR
    logic [DATA_WIDTH-1:0]    rdst_data;

    // Per-source override of the ready bit and the operand data
    logic [NUM_SRC-1:0]       rdy_ovrd;
    logic [DATA_WIDTH-1:0]    data_ovrd [0:NUM_SRC-1];

    modport producer (
        output op, op_is, pc, imm, rdst, rdst_data, rdy_ovrd, data_ovrd
    );

    modport operand (
        input rdy_ovrd, data_ovrd
    );

    modport dispatch (
        input op, op_is, pc, imm, rdst, rdst_data
    );

endinterface

// File: src/insn_decoder.sv
// RV32I instruction decoder
// Purely combinational: builds immediates, jump targets and link data and
// maps the opcode, funct3 and funct7 onto an internal operation and class

module insn_decoder import decode_pkg::*; (
    input  logic [DATA_WIDTH-1:0]    i_fetch_insn,
    input  logic [ADDR_WIDTH-1:0]    i_fetch_pc,
    output logic [REG_IDX_WIDTH-1:0] o_lookup_rsrc [0:NUM_SRC-1],
    decoded_insn_if.producer         dec
);

    assign o_lookup_rsrc[0] = i_fetch_insn[19:15];
    assign o_lookup_rsrc[1] = i_fetch_insn[24:20];

    always_comb begin
        rv_opcode_t               opcode;
        op_t                      op;
        logic [REG_IDX_WIDTH-1:0] rdst;
        logic [2:0]               funct3;
        logic                     funct7_is_0;
        logic                     funct7_is_32;
        logic [DATA_WIDTH-1:0]    imm_i;
        logic [DATA_WIDTH-1:0]    imm_s;
        logic [DATA_WIDTH-1:0]    imm_b;
        logic [DATA_WIDTH-1:0]    imm_u;
        logic [DATA_WIDTH-1:0]    imm_j;
        logic [ADDR_WIDTH-1:0]    jmp_pc;
        logic [ADDR_WIDTH-1:0]    pc_plus_4;

        imm_i = {{(DATA_WIDTH-11){i_fetch_insn[31]}}, i_fetch_insn[30:20]};
        imm_s = {{(DATA_WIDTH-11){i_fetch_insn[31]}}, i_fetch_insn[30:25], i_fetch_insn[11:7]};
        imm_b = {{(DATA_WIDTH-12){i_fetch_insn[31]}}, i_fetch_insn[7], i_fetch_insn[30:25],
                 i_fetch_insn[11:8], 1'b0};
        imm_u = {i_fetch_insn[31:12], 12'b0};
        imm_j = {{(DATA_WIDTH-20){i_fetch_insn[31]}}, i_fetch_insn[19:12], i_fetch_insn[20],
                 i_fetch_insn[30:21], 1'b0};

        opcode       = rv_opcode_t'(i_fetch_insn[6:0]);
        rdst         = i_fetch_insn[11:7];
        funct3       = i_fetch_insn[14:12];
        funct7_is_0  = (i_fetch_insn[31:25] == 7'b0000000);
        funct7_is_32 = (i_fetch_insn[31:25] == 7'b0100000);

        // Bit 2 of the opcode separates JAL from BRANCH
        jmp_pc    = (i_fetch_insn[2] ? imm_j : imm_b) + i_fetch_pc;
        pc_plus_4 = i_fetch_pc + ADDR_WIDTH'(4);

        // Defaults describe a plain register-register op
        op            = OP_UNDEFINED;
        dec.op_is     = OP_IS_OP;
        dec.pc        = i_fetch_pc;
        dec.imm       = imm_i;
        dec.rdst      = rdst;
        dec.rdst_data = '0;
        dec.rdy_ovrd  = 2'b00;
        dec.data_ovrd = '{'0, '0};

        unique case (opcode)
            RV_OPCODE_OPIMM: begin
                unique case (funct3)
                    3'b000:  op = OP_ADD;
                    3'b001:  op = funct7_is_0 ? OP_SLL : OP_UNDEFINED;
                    3'b010:  op = OP_LT;
                    3'b011:  op = OP_LTU;
                    3'b100:  op = OP_XOR;
                    3'b101:  op = funct7_is_0 ? OP_SRL : (funct7_is_32 ? OP_SRA : OP_UNDEFINED);
                    3'b110:  op = OP_OR;
                    default: op = OP_AND;
                endcase
                dec.rdy_ovrd  = 2'b10;
                dec.data_ovrd = '{'0, imm_i};
            end
            RV_OPCODE_LUI: begin
                // Computed as x0 plus the upper immediate
                op            = OP_ADD;
                dec.imm       = imm_u;
                dec.rdy_ovrd  = 2'b11;
                dec.data_ovrd = '{'0, imm_u};
            end
            RV_OPCODE_AUIPC: begin
                op            = OP_ADD;
                dec.imm       = imm_u;
                dec.rdy_ovrd  = 2'b11;
                dec.data_ovrd = '{i_fetch_pc, imm_u};
            end
            RV_OPCODE_OP: begin
                if (funct7_is_0) begin
                    unique case (funct3)
                        3'b000:  op = OP_ADD;
                        3'b001:  op = OP_SLL;
                        3'b010:  op = OP_LT;
                        3'b011:  op = OP_LTU;
                        3'b100:  op = OP_XOR;
                        3'b101:  op = OP_SRL;
                        3'b110:  op = OP_OR;
                        default: op = OP_AND;
                    endcase
                end else if (funct7_is_32) begin
                    unique case (funct3)
                        3'b000:  op = OP_SUB;
                        3'b101:  op = OP_SRA;
                        default: op = OP_UNDEFINED;
                    endcase
                end
            end
            RV_OPCODE_JAL: begin
                op            = OP_ADD;
                dec.op_is     = OP_IS_JL;
                dec.pc        = jmp_pc;
                dec.imm       = imm_j;
                dec.rdst_data = pc_plus_4;
                dec.rdy_ovrd  = 2'b11;
                dec.data_ovrd = '{i_fetch_pc, imm_j};
            end
            RV_OPCODE_JALR: begin
                // The target depends on rs1, so the fetch pc is passed on
                op            = (funct3 == 3'b000) ? OP_ADD : OP_UNDEFINED;
                dec.op_is     = OP_IS_JL;
                dec.rdst_data = pc_plus_4;
                dec.rdy_ovrd  = 2'b10;
                dec.data_ovrd = '{'0, imm_i};
            end
            RV_OPCODE_BRANCH: begin
                unique case (funct3)
                    3'b000:  op = OP_EQ;
                    3'b001:  op = OP_NE;
                    3'b100:  op = OP_LT;
                    3'b101:  op = OP_GE;
                    3'b110:  op = OP_LTU;
                    3'b111:  op = OP_GEU;
                    default: op = OP_UNDEFINED;
                endcase
                dec.op_is = OP_IS_BR;
                dec.pc    = jmp_pc;
                dec.imm   = imm_b;
                dec.rdst  = '0;
            end
            RV_OPCODE_LOAD: begin
                unique case (funct3)
                    3'b000:  op = OP_LB;
                    3'b001:  op = OP_LH;
                    3'b010:  op = OP_LW;
                    3'b100:  op = OP_LBU;
                    3'b101:  op = OP_LHU;
                    default: op = OP_UNDEFINED;
                endcase
                dec.op_is     = OP_IS_LD;
                dec.rdy_ovrd  = 2'b10;
                dec.data_ovrd = '{'0, imm_i};
            end
            RV_OPCODE_STORE: begin
                // Both registers are needed, the offset travels in imm
                unique case (funct3)
                    3'b000:  op = OP_SB;
                    3'b001:  op = OP_SH;
                    3'b010:  op = OP_SW;
                    default: op = OP_UNDEFINED;
                endcase
                dec.op_is = OP_IS_ST;
                dec.imm   = imm_s;
                dec.rdst  = '0;
            end
            default: begin
                op = OP_UNDEFINED;
            end
        endcase

        // An undefined op must neither wait on sources nor rename a register
        if (op == OP_UNDEFINED) begin
            dec.rdy_ovrd = '1;
            dec.rdst     = '0;
        end

        dec.op = op;
    end

endmodule

// File: src/src_operand_select.sv
// Source operand selection
// Picks the ready bit and data of each source from the decoder override,
// the register alias table or the reorder buffer, in that order

module src_operand_select import decode_pkg::*; (
    input  logic                  i_rat_rdy  [0:NUM_SRC-1],
    input  logic [DATA_WIDTH-1:0] i_rat_data [0:NUM_SRC-1],
    input  logic                  i_rob_rdy  [0:NUM_SRC-1],
    input  logic [DATA_WIDTH-1:0] i_rob_data [0:NUM_SRC-1],
    decoded_insn_if.operand       dec,
    output logic                  o_src_rdy  [0:NUM_SRC-1],
    output logic [DATA_WIDTH-1:0] o_src_data [0:NUM_SRC-1]
);

    // A source that is not ready anywhere keeps the ROB data slot and waits
    // for its tag on the result bus
    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            o_src_rdy[i] = dec.rdy_ovrd[i] | i_rat_rdy[i] | i_rob_rdy[i];

            if (dec.rdy_ovrd[i]) begin
                o_src_data[i] = dec.data_ovrd[i];
            end else if (i_rat_rdy[i]) begin
                o_src_data[i] = i_rat_data[i];
            end else begin
                o_src_data[i] = i_rob_data[i];
            end
        end
    end

endmodule

// File: src/dispatch_regs.sv
// Dispatch registers
// Hold the ROB and RS dispatch fields for one cycle after decode

module dispatch_regs import decode_pkg::*; (
    input  logic                     clk,
    input  logic                     i_rst,
    decoded_insn_if.dispatch         dec,
    input  logic                     i_src_rdy  [0:NUM_SRC-1],
    input  logic [DATA_WIDTH-1:0]    i_src_data [0:NUM_SRC-1],
    input  logic [ROB_TAG_WIDTH-1:0] i_src_tag  [0:NUM_SRC-1],
    input  logic [ROB_TAG_WIDTH-1:0] i_dst_tag,

    // ROB dispatch
    output op_is_t                   o_rob_op_is,
    output logic [ADDR_WIDTH-1:0]    o_rob_pc,
    output logic [REG_IDX_WIDTH-1:0] o_rob_rdst,
    output logic [DATA_WIDTH-1:0]    o_rob_rdst_data,

    // RS dispatch
    output op_t                      o_rs_op,
    output logic [DATA_WIDTH-1:0]    o_rs_imm,
    output logic [ROB_TAG_WIDTH-1:0] o_rs_dst_tag,
    output logic                     o_rs_src_rdy  [0:NUM_SRC-1],
    output logic [DATA_WIDTH-1:0]    o_rs_src_data [0:NUM_SRC-1],
    output logic [ROB_TAG_WIDTH-1:0] o_rs_src_tag  [0:NUM_SRC-1]
);

    // Class and destination are cleared so no stale rename shows after reset
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_rob_op_is <= OP_IS_OP;
            o_rob_rdst  <= '0;
        end else begin
            o_rob_op_is <= dec.op_is;
            o_rob_rdst  <= dec.rdst;
        end
    end

    // Payload is captured every cycle, the reserve strobe qualifies it
    always_ff @(posedge clk) begin
        o_rob_pc        <= dec.pc;
        o_rob_rdst_data <= dec.rdst_data;

        o_rs_op         <= dec.op;
        o_rs_imm        <= dec.imm;
        o_rs_dst_tag    <= i_dst_tag;
        o_rs_src_rdy    <= i_src_rdy;
        o_rs_src_data   <= i_src_data;
        o_rs_src_tag    <= i_src_tag;
    end

endmodule

// File: src/rv_decode.sv
// RV32I decode and dispatch stage
// Decodes one instruction per cycle, renames and reserves in the fetch
// cycle, and dispatches to the ROB and RS on the following cycle

module rv_decode import decode_pkg::*; (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_flush,
    input  logic                     i_rob_stall,
    input  logic                     i_rs_stall,

    // Fetch
    input  logic [ADDR_WIDTH-1:0]    i_fetch_pc,
    input  logic [DATA_WIDTH-1:0]    i_fetch_insn,
    input  logic                     i_fetch_valid,
    output logic                     o_decode_stall,

    // RAT lookup
    output logic [REG_IDX_WIDTH-1:0] o_rat_lookup_rsrc [0:NUM_SRC-1],
    input  logic                     i_rat_lookup_rdy  [0:NUM_SRC-1],
    input  logic [DATA_WIDTH-1:0]    i_rat_lookup_data [0:NUM_SRC-1],
    input  logic [ROB_TAG_WIDTH-1:0] i_rat_lookup_tag  [0:NUM_SRC-1],

    // ROB lookup and the tag that renames the destination
    input  logic                     i_rob_lookup_rdy  [0:NUM_SRC-1],
    input  logic [DATA_WIDTH-1:0]    i_rob_lookup_data [0:NUM_SRC-1],
    input  logic [ROB_TAG_WIDTH-1:0] i_rob_dst_tag,

    // Rename and reserve
    output logic [REG_IDX_WIDTH-1:0] o_rat_rename_rdst,
    output logic                     o_rs_reserve_en,
    output op_is_t                   o_rs_reserve_op_is,
    output logic                     o_rob_reserve_en,

    // ROB dispatch
    output op_is_t                   o_rob_dispatch_op_is,
    output logic [ADDR_WIDTH-1:0]    o_rob_dispatch_pc,
    output logic [REG_IDX_WIDTH-1:0] o_rob_dispatch_rdst,
    output logic [DATA_WIDTH-1:0]    o_rob_dispatch_rdst_data,

    // RS dispatch
    output op_t                      o_rs_dispatch_op,
    output logic [DATA_WIDTH-1:0]    o_rs_dispatch_imm,
    output logic [ROB_TAG_WIDTH-1:0] o_rs_dispatch_dst_tag,
    output logic                     o_rs_dispatch_src_rdy  [0:NUM_SRC-1],
    output logic [DATA_WIDTH-1:0]    o_rs_dispatch_src_data [0:NUM_SRC-1],
    output logic [ROB_TAG_WIDTH-1:0] o_rs_dispatch_src_tag  [0:NUM_SRC-1]
);

    logic                  stall;
    logic                  reserve_en;
    logic                  src_rdy  [0:NUM_SRC-1];
    logic [DATA_WIDTH-1:0] src_data [0:NUM_SRC-1];

    decoded_insn_if dec_if ();

    assign stall          = i_rob_stall | i_rs_stall;
    assign o_decode_stall = stall;

    // Reserve only for a valid instruction that is neither flushed nor stalled
    assign reserve_en         = i_fetch_valid & ~i_flush & ~stall;
    assign o_rob_reserve_en   = reserve_en;
    assign o_rs_reserve_en    = reserve_en;
    assign o_rs_reserve_op_is = dec_if.op_is;
    assign o_rat_rename_rdst  = dec_if.rdst;

    insn_decoder u_insn_decoder (
        .i_fetch_insn  (i_fetch_insn),
        .i_fetch_pc    (i_fetch_pc),
        .o_lookup_rsrc (o_rat_lookup_rsrc),
        .dec           (dec_if.producer)
    );

    src_operand_select u_src_operand_select (
        .i_rat_rdy  (i_rat_lookup_rdy),
        .i_rat_data (i_rat_lookup_data),
        .i_rob_rdy  (i_rob_lookup_rdy),
        .i_rob_data (i_rob_lookup_data),
        .dec        (dec_if.operand),
        .o_src_rdy  (src_rdy),
        .o_src_data (src_data)
    );

    dispatch_regs u_dispatch_regs (
        .clk             (clk),
        .i_rst           (i_rst),
        .dec             (dec_if.dispatch),
        .i_src_rdy       (src_rdy),
        .i_src_data      (src_data),
        .i_src_tag       (i_rat_lookup_tag),
        .i_dst_tag       (i_rob_dst_tag),
        .o_rob_op_is     (o_rob_dispatch_op_is),
        .o_rob_pc        (o_rob_dispatch_pc),
        .o_rob_rdst      (o_rob_dispatch_rdst),
        .o_rob_rdst_data (o_rob_dispatch_rdst_data),
        .o_rs_op         (o_rs_dispatch_op),
        .o_rs_imm        (o_rs_dispatch_imm),
        .o_rs_dst_tag    (o_rs_dispatch_dst_tag),
        .o_rs_src_rdy    (o_rs_dispatch_src_rdy),
        .o_rs_src_data   (o_rs_dispatch_src_data),
        .o_rs_src_tag    (o_rs_dispatch_src_tag)
    );

endmodule

// File: verif/decode_model.svh
// Reference model of the RV32I decode stage
// Expected decoded fields of one instruction word and the source operand choice

`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
    op_t                                op;
    op_is_t                             op_is;
    logic [ADDR_WIDTH-1:0]              pc;
    logic [DATA_WIDTH-1:0]              imm;
    logic [REG_IDX_WIDTH-1:0]           rdst;
    logic [DATA_WIDTH-1:0]              rdst_data;
    logic [NUM_SRC-1:0]                 ovrd;
    logic [NUM_SRC-1:0][DATA_WIDTH-1:0] ovrd_data;
} decode_exp_t;

// Register-register ALU mapping of funct3
function automatic op_t alu_op(input logic [2:0] f3);
    case (f3)
        3'd0:    return OP_ADD;
        3'd1:    return OP_SLL;
        3'd2:    return OP_LT;
        3'd3:    return OP_LTU;
        3'd4:    return OP_XOR;
        3'd5:    return OP_SRL;
        3'd6:    return OP_OR;
        default: return OP_AND;
    endcase
endfunction

function automatic decode_exp_t decode_expect(input logic [31:0] insn, input logic [31:0] pc);
    decode_exp_t e;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [2:0]  f3;
    logic [6:0]  f7;

    // Immediate layouts as given by the RV32I base encoding
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_u = {insn[31:12], 12'h000};
    imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    f3 = insn[14:12];
    f7 = insn[31:25];

    e = '0;
    e.op = OP_UNDEFINED;
    e.op_is = OP_IS_OP;
    e.pc = pc;
    e.imm = imm_i;
    e.rdst = insn[11:7];

    case (insn[6:0])
        RV_OPCODE_OPIMM: begin
            e.op = alu_op(f3);
            if (f3 == 3'd1 && f7 != 7'h00) begin
                e.op = OP_UNDEFINED;
            end
            if (f3 == 3'd5 && f7 == 7'h20) begin
                e.op = OP_SRA;
            end else if (f3 == 3'd5 && f7 != 7'h00) begin
                e.op = OP_UNDEFINED;
            end
            e.ovrd = 2'b10;
            e.ovrd_data[1] = imm_i;
        end
        RV_OPCODE_LUI: begin
            e.op = OP_ADD;
            e.imm = imm_u;
            e.ovrd = 2'b11;
            e.ovrd_data[1] = imm_u;
        end
        RV_OPCODE_AUIPC: begin
            e.op = OP_ADD;
            e.imm = imm_u;
            e.ovrd = 2'b11;
            e.ovrd_data[0] = pc;
            e.ovrd_data[1] = imm_u;
        end
        RV_OPCODE_OP: begin
            if (f7 == 7'h00) begin
                e.op = alu_op(f3);
            end else if (f7 == 7'h20 && f3 == 3'd0) begin
                e.op = OP_SUB;
            end else if (f7 == 7'h20 && f3 == 3'd5) begin
                e.op = OP_SRA;
            end
        end
        RV_OPCODE_JAL: begin
            e.op = OP_ADD;
            e.op_is = OP_IS_JL;
            e.pc = pc + imm_j;
            e.imm = imm_j;
            e.rdst_data = pc + 32'd4;
            e.ovrd = 2'b11;
            e.ovrd_data[0] = pc;
            e.ovrd_data[1] = imm_j;
        end
        RV_OPCODE_JALR: begin
            if (f3 == 3'd0) begin
                e.op = OP_ADD;
            end
            e.op_is = OP_IS_JL;
            e.rdst_data = pc + 32'd4;
            e.ovrd = 2'b10;
            e.ovrd_data[1] = imm_i;
        end
        RV_OPCODE_BRANCH: begin
            case (f3)
                3'd0:    e.op = OP_EQ;
                3'd1:    e.op = OP_NE;
                3'd4:    e.op = OP_LT;
                3'd5:    e.op = OP_GE;
                3'd6:    e.op = OP_LTU;
                3'd7:    e.op = OP_GEU;
                default: e.op = OP_UNDEFINED;
            endcase
            e.op_is = OP_IS_BR;
            e.pc = pc + imm_b;
            e.imm = imm_b;
            e.rdst = '0;
        end
        RV_OPCODE_LOAD: begin
            case (f3)
                3'd0:    e.op = OP_LB;
                3'd1:    e.op = OP_LH;
                3'd2:    e.op = OP_LW;
                3'd4:    e.op = OP_LBU;
                3'd5:    e.op = OP_LHU;
                default: e.op = OP_UNDEFINED;
            endcase
            e.op_is = OP_IS_LD;
            e.ovrd = 2'b10;
            e.ovrd_data[1] = imm_i;
        end
        RV_OPCODE_STORE: begin
            case (f3)
                3'd0:    e.op = OP_SB;
                3'd1:    e.op = OP_SH;
                3'd2:    e.op = OP_SW;
                default: e.op = OP_UNDEFINED;
            endcase
            e.op_is = OP_IS_ST;
            e.imm = imm_s;
            e.rdst = '0;
        end
        default: begin
            e.op = OP_UNDEFINED;
        end
    endcase

    // Undefined ops never wait on sources and rename nothing
    if (e.op == OP_UNDEFINED) begin
        e.ovrd = 2'b11;
        e.rdst = '0;
    end
    return e;
endfunction

// Returns the ready bit above the data word of one source
function automatic logic [DATA_WIDTH:0] pick_source(
    input logic ovrd, input logic [DATA_WIDTH-1:0] ovrd_data,
    input logic rat_rdy, input logic [DATA_WIDTH-1:0] rat_data,
    input logic rob_rdy, input logic [DATA_WIDTH-1:0] rob_data);
    logic [DATA_WIDTH-1:0] data;

    if (ovrd) begin
        data = ovrd_data;
    end else if (rat_rdy) begin
        data = rat_data;
    end else begin
        data = rob_data;
    end
    return {ovrd | rat_rdy | rob_rdy, data};
endfunction

`endif

// File: verif/tb_rv_decode.sv
// Testbench for the RV32I decode and dispatch stage
// Random instructions and lookup results from an LFSR are checked against
// a reference model, in the fetch cycle and one edge later

module tb_rv_decode import decode_pkg::*; ();

    `include "decode_model.svh"

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_TESTS       = 2000;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS + 50;
    localparam logic [31:0] LFSR_SEED = 32'hefd775e3;

    logic                     clk;
    logic                     i_rst;
    logic                     i_flush;
    logic                     i_rob_stall;
    logic                     i_rs_stall;
    logic [ADDR_WIDTH-1:0]    i_fetch_pc;
    logic [DATA_WIDTH-1:0]    i_fetch_insn;
    logic                     i_fetch_valid;
    logic                     o_decode_stall;
    logic [REG_IDX_WIDTH-1:0] o_rat_lookup_rsrc [0:NUM_SRC-1];
    logic                     i_rat_lookup_rdy  [0:NUM_SRC-1];
    logic [DATA_WIDTH-1:0]    i_rat_lookup_data [0:NUM_SRC-1];
    logic [ROB_TAG_WIDTH-1:0] i_rat_lookup_tag  [0:NUM_SRC-1];
    logic                     i_rob_lookup_rdy  [0:NUM_SRC-1];
    logic [DATA_WIDTH-1:0]    i_rob_lookup_data [0:NUM_SRC-1];
    logic [ROB_TAG_WIDTH-1:0] i_rob_dst_tag;
    logic [REG_IDX_WIDTH-1:0] o_rat_rename_rdst;
    logic                     o_rs_reserve_en;
    op_is_t                   o_rs_reserve_op_is;
    logic                     o_rob_reserve_en;
    op_is_t                   o_rob_dispatch_op_is;
    logic [ADDR_WIDTH-1:0]    o_rob_dispatch_pc;
    logic [REG_IDX_WIDTH-1:0] o_rob_dispatch_rdst;
    logic [DATA_WIDTH-1:0]    o_rob_dispatch_rdst_data;
    op_t                      o_rs_dispatch_op;
    logic [DATA_WIDTH-1:0]    o_rs_dispatch_imm;
    logic [ROB_TAG_WIDTH-1:0] o_rs_dispatch_dst_tag;
    logic                     o_rs_dispatch_src_rdy  [0:NUM_SRC-1];
    logic [DATA_WIDTH-1:0]    o_rs_dispatch_src_data [0:NUM_SRC-1];
    logic [ROB_TAG_WIDTH-1:0] o_rs_dispatch_src_tag  [0:NUM_SRC-1];

    // Expected dispatch fields of the previous fetch cycle
    decode_exp_t              exp_dec;
    logic                     exp_src_rdy  [0:NUM_SRC-1];
    logic [DATA_WIDTH-1:0]    exp_src_data [0:NUM_SRC-1];
    logic [ROB_TAG_WIDTH-1:0] exp_src_tag  [0:NUM_SRC-1];
    logic [ROB_TAG_WIDTH-1:0] exp_dst_tag;

    logic [31:0]              lfsr_state;

    rv_decode i_rv_decode (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Steps a Galois LFSR once per bit and collects the output bits
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;

        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
        end
        return v;
    endfunction

    task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Fail %s got 0x%h expected 0x%h at time %0t", name, got, exp, $time);
        $display("STATUS: FAIL");
        $fatal(1, "Value mismatch on %s", name);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else fail_value(name, got, exp);
    endtask

    task drive_stimulus(input logic allow_valid);
        logic [3:0]  sel;
        logic [1:0]  f7_sel;
        logic [6:0]  opcode;
        logic [6:0]  funct7;
        logic [17:0] fields;
        int          s;

        sel = 4'(random_bits(4));
        case (sel)
            4'd0:    opcode = RV_OPCODE_OPIMM;
            4'd1:    opcode = RV_OPCODE_LUI;
            4'd2:    opcode = RV_OPCODE_AUIPC;
            4'd3:    opcode = RV_OPCODE_OP;
            4'd4:    opcode = RV_OPCODE_JAL;
            4'd5:    opcode = RV_OPCODE_JALR;
            4'd6:    opcode = RV_OPCODE_BRANCH;
            4'd7:    opcode = RV_OPCODE_LOAD;
            4'd8:    opcode = RV_OPCODE_STORE;
            default: opcode = 7'(random_bits(7));
        endcase
        // Favour the two funct7 values that select real operations
        f7_sel = 2'(random_bits(2));
        if (f7_sel == 2'd0) begin
            funct7 = 7'h00;
        end else if (f7_sel == 2'd1) begin
            funct7 = 7'h20;
        end else begin
            funct7 = 7'(random_bits(7));
        end
        fields = 18'(random_bits(18));

        i_fetch_insn  <= {funct7, fields, opcode};
        i_fetch_pc    <= random_bits(ADDR_WIDTH);
        i_fetch_valid <= allow_valid & (random_bits(2) != 32'd0);
        i_flush       <= (random_bits(3) == 32'd7);
        i_rob_stall   <= (random_bits(2) == 32'd3);
        i_rs_stall    <= (random_bits(2) == 32'd3);
        i_rob_dst_tag <= ROB_TAG_WIDTH'(random_bits(ROB_TAG_WIDTH));
        for (s = 0; s < NUM_SRC; s = s + 1) begin
            i_rat_lookup_rdy[s]  <= (random_bits(1) != 32'd0);
            i_rat_lookup_data[s] <= random_bits(DATA_WIDTH);
            i_rat_lookup_tag[s]  <= ROB_TAG_WIDTH'(random_bits(ROB_TAG_WIDTH));
            i_rob_lookup_rdy[s]  <= (random_bits(1) != 32'd0);
            i_rob_lookup_data[s] <= random_bits(DATA_WIDTH);
        end
    endtask

    // Fetch-cycle outputs against the inputs that are present now
    task automatic check_comb();
        decode_exp_t e;
        logic        exp_reserve;

        e = decode_expect(i_fetch_insn, i_fetch_pc);
        exp_reserve = i_fetch_valid & ~i_flush & ~i_rob_stall & ~i_rs_stall;
        check_eq("o_rob_reserve_en", 32'(o_rob_reserve_en), 32'(exp_reserve));
        check_eq("o_rs_reserve_en", 32'(o_rs_reserve_en), 32'(exp_reserve));
        check_eq("o_decode_stall", 32'(o_decode_stall), 32'(i_rob_stall | i_rs_stall));
        check_eq("o_rat_lookup_rsrc[0]", 32'(o_rat_lookup_rsrc[0]), 32'(i_fetch_insn[19:15]));
        check_eq("o_rat_lookup_rsrc[1]", 32'(o_rat_lookup_rsrc[1]), 32'(i_fetch_insn[24:20]));
        check_eq("o_rat_rename_rdst", 32'(o_rat_rename_rdst), 32'(e.rdst));
        check_eq("o_rs_reserve_op_is", 32'(o_rs_reserve_op_is), 32'(e.op_is));
    endtask

    task automatic capture_expect();
        logic [DATA_WIDTH:0] pick;

        exp_dec = decode_expect(i_fetch_insn, i_fetch_pc);
        for (int s = 0; s < NUM_SRC; s++) begin
            pick = pick_source(exp_dec.ovrd[s], exp_dec.ovrd_data[s],
                               i_rat_lookup_rdy[s], i_rat_lookup_data[s],
                               i_rob_lookup_rdy[s], i_rob_lookup_data[s]);
            exp_src_rdy[s]  = pick[DATA_WIDTH];
            exp_src_data[s] = pick[DATA_WIDTH-1:0];
            exp_src_tag[s]  = i_rat_lookup_tag[s];
        end
        exp_dst_tag = i_rob_dst_tag;
    endtask

    task automatic check_registered();
        check_eq("o_rs_dispatch_op", 32'(o_rs_dispatch_op), 32'(exp_dec.op));
        check_eq("o_rob_dispatch_op_is", 32'(o_rob_dispatch_op_is), 32'(exp_dec.op_is));
        check_eq("o_rs_dispatch_imm", o_rs_dispatch_imm, exp_dec.imm);
        check_eq("o_rob_dispatch_pc", o_rob_dispatch_pc, exp_dec.pc);
        check_eq("o_rob_dispatch_rdst", 32'(o_rob_dispatch_rdst), 32'(exp_dec.rdst));
        check_eq("o_rob_dispatch_rdst_data", o_rob_dispatch_rdst_data, exp_dec.rdst_data);
        check_eq("o_rs_dispatch_dst_tag", 32'(o_rs_dispatch_dst_tag), 32'(exp_dst_tag));
        for (int s = 0; s < NUM_SRC; s++) begin
            check_eq($sformatf("o_rs_dispatch_src_rdy[%0d]", s),
                     32'(o_rs_dispatch_src_rdy[s]), 32'(exp_src_rdy[s]));
            check_eq($sformatf("o_rs_dispatch_src_data[%0d]", s),
                     o_rs_dispatch_src_data[s], exp_src_data[s]);
            check_eq($sformatf("o_rs_dispatch_src_tag[%0d]", s),
                     32'(o_rs_dispatch_src_tag[s]), 32'(exp_src_tag[s]));
        end
    endtask

    initial begin
        lfsr_state    = LFSR_SEED;
        i_rst         = 1'b1;
        i_flush       = 1'b0;
        i_rob_stall   = 1'b0;
        i_rs_stall    = 1'b0;
        i_fetch_pc    = '0;
        i_fetch_insn  = '0;
        i_fetch_valid = 1'b0;
        i_rob_dst_tag = '0;
        for (int s = 0; s < NUM_SRC; s++) begin
            i_rat_lookup_rdy[s]  = 1'b0;
            i_rat_lookup_data[s] = '0;
            i_rat_lookup_tag[s]  = '0;
            i_rob_lookup_rdy[s]  = 1'b0;
            i_rob_lookup_data[s] = '0;
        end

        // Random fetch words during reset, but never a valid one
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            drive_stimulus(c == RESET_CYCLES - 1);
            if (c == RESET_CYCLES - 1) begin
                i_rst <= 1'b0;
            end
            // Class and destination stay cleared whatever word was decoded
            @(negedge clk);
            check_eq("o_rob_dispatch_rdst", 32'(o_rob_dispatch_rdst), 32'd0);
            check_eq("o_rob_dispatch_op_is", 32'(o_rob_dispatch_op_is), 32'(OP_IS_OP));
        end

        check_comb();
        capture_expect();

        for (int n = 0; n < NUM_TESTS; n++) begin
            @(posedge clk);
            drive_stimulus(1'b1);
            @(negedge clk);
            check_registered();
            check_comb();
            capture_expect();
        end

        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("Timeout, the run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: build.f
+incdir+verif
src/decode_pkg.sv
src/decoded_insn_if.sv
src/insn_decoder.sv
src/src_operand_select.sv
src/dispatch_regs.sv
src/rv_decode.sv
verif/tb_rv_decode.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f build.f --top-module tb_rv_decode -o sim_rv_decode
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_rv_decode)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1
